/* rtl/fixed_pkg.sv */
`default_nettype none

package fixed_pkg;

    // input samples are Q1.7
    localparam int din_width = 8;
    localparam int din_point = 7;

    // twiddles are Q2.14, so +1.0 fits without wrapping
    localparam int twidd_width = 16;
    localparam int twidd_point = 14;

    localparam int dft_len = 128;
    localparam int twiddle_bin = 5;

    // growth through comb, multiplier and integrator
    localparam int comb_width = din_width + 1;
    localparam int prod_width = comb_width + twidd_width;
    localparam int mod_width = prod_width + 1;
    localparam int mod_point = din_point + twidd_point;
    localparam int integ_width = mod_width + $clog2(dft_len);

    localparam int dout_width = 32;
    localparam int dout_point = 16;

    // integrator bits that survive the fraction truncation
    localparam int frac_drop = mod_point - dout_point;
    localparam int trunc_width = integ_width - frac_drop;

    // forward kernel cos - j*sin, packed as {re, im}
    function automatic logic [2*twidd_width-1:0] twiddle_value(input int m);
        real theta;
        real scale;
        logic signed [twidd_width-1:0] re;
        logic signed [twidd_width-1:0] im;
        theta = 2.0 * 3.14159265358979 * real'(twiddle_bin) * real'(m) / real'(dft_len);
        scale = real'(1 << twidd_point);
        re = twidd_width'(int'($cos(theta) * scale));
        im = twidd_width'(int'(-$sin(theta) * scale));
        return {re, im};
    endfunction

endpackage

`default_nettype wire

/* rtl/msdft_pkg.sv */
`default_nettype none

package msdft_pkg;

    import fixed_pkg::*;

    // position inside the sliding window
    typedef logic [$clog2(dft_len)-1:0] win_idx_t;

    typedef struct packed {
        logic signed [din_width-1:0] re;
        logic signed [din_width-1:0] im;
    } cplx_in_t;

    // din minus the sample leaving the window
    typedef struct packed {
        logic signed [comb_width-1:0] re;
        logic signed [comb_width-1:0] im;
    } cplx_comb_t;

    typedef struct packed {
        logic signed [twidd_width-1:0] re;
        logic signed [twidd_width-1:0] im;
    } cplx_twidd_t;

    // full precision product of comb and twiddle
    typedef struct packed {
        logic signed [mod_width-1:0] re;
        logic signed [mod_width-1:0] im;
    } cplx_mod_t;

    typedef struct packed {
        logic signed [integ_width-1:0] re;
        logic signed [integ_width-1:0] im;
    } cplx_integ_t;

    typedef struct packed {
        logic signed [dout_width-1:0] re;
        logic signed [dout_width-1:0] im;
    } cplx_out_t;

endpackage

`default_nettype wire

/* rtl/sample_comb.sv */
`default_nettype none

module sample_comb (
    input wire clk,
    input wire rst,
    input wire msdft_pkg::cplx_in_t din,
    input wire din_valid,
    input wire msdft_pkg::win_idx_t window_len_m1,
    output msdft_pkg::cplx_comb_t dout,
    output logic dout_valid
);

    import fixed_pkg::*;
    import msdft_pkg::*;

    cplx_in_t mem [dft_len];
    win_idx_t wr_ptr;
    win_idx_t rd_ptr;
    win_idx_t fill_cnt;
    logic fill_done;
    cplx_in_t old;

    // wraps modulo dft_len, a full window reads the slot about to be overwritten
    assign rd_ptr = wr_ptr - window_len_m1 - 1'b1;

    // nothing has left the window until it has been filled once
    assign old = fill_done ? mem[rd_ptr] : '0;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem[wr_ptr] <= din;
            dout.re <= comb_width'(din.re) - comb_width'(old.re);
            dout.im <= comb_width'(din.im) - comb_width'(old.im);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            fill_cnt <= '0;
            fill_done <= 1'b0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
            if (din_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (!fill_done) begin
                    if (fill_cnt == window_len_m1) begin
                        fill_done <= 1'b1;
                    end else begin
                        fill_cnt <= fill_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/twiddle_rom.sv */
`default_nettype none

module twiddle_rom (
    input wire clk,
    input wire msdft_pkg::win_idx_t addr,
    input wire rd,
    output msdft_pkg::cplx_twidd_t twidd
);

    import fixed_pkg::*;
    import msdft_pkg::*;

    cplx_twidd_t twidd_table [dft_len];

    // constant table, one entry per window position
    for (genvar m = 0; m < dft_len; m++) begin : g_table
        assign twidd_table[m] = cplx_twidd_t'(twiddle_value(m));
    end

    // one cycle read latency, output holds between reads
    always_ff @(posedge clk) begin
        if (rd) begin
            twidd <= twidd_table[addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/complex_mult.sv */
`default_nettype none

module complex_mult (
    input wire clk,
    input wire rst,
    input wire msdft_pkg::cplx_comb_t a,
    input wire msdft_pkg::cplx_twidd_t b,
    input wire in_valid,
    output msdft_pkg::cplx_mod_t prod,
    output logic out_valid
);

    import fixed_pkg::*;
    import msdft_pkg::*;

    logic signed [prod_width-1:0] ac;
    logic signed [prod_width-1:0] bd;
    logic signed [prod_width-1:0] ad;
    logic signed [prod_width-1:0] bc;
    logic pp_valid;

    // stage 1 partial products
    always_ff @(posedge clk) begin
        ac <= a.re * b.re;
        bd <= a.im * b.im;
        ad <= a.re * b.im;
        bc <= a.im * b.re;
    end

    // stage 2 combine, one guard bit keeps it exact
    always_ff @(posedge clk) begin
        prod.re <= mod_width'(ac) - mod_width'(bd);
        prod.im <= mod_width'(ad) + mod_width'(bc);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pp_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            pp_valid <= in_valid;
            out_valid <= pp_valid;
        end
    end

endmodule

`default_nettype wire

/* rtl/signed_cast.sv */
`default_nettype none

module signed_cast (
    input wire clk,
    input wire rst,
    input wire msdft_pkg::cplx_integ_t din,
    input wire din_valid,
    output msdft_pkg::cplx_out_t dout,
    output logic dout_valid
);

    import fixed_pkg::*;
    import msdft_pkg::*;

    logic signed [trunc_width-1:0] trunc_re;
    logic signed [trunc_width-1:0] trunc_im;
    logic signed [dout_width-1:0] cast_re;
    logic signed [dout_width-1:0] cast_im;

    // dropping low bits of two's complement rounds toward minus infinity
    assign trunc_re = din.re[integ_width-1:frac_drop];
    assign trunc_im = din.im[integ_width-1:frac_drop];

    if (trunc_width > dout_width) begin : g_sat
        function automatic logic signed [dout_width-1:0] sat_rail(
            input logic signed [trunc_width-1:0] t
        );
            logic [trunc_width-dout_width:0] top;
            top = t[trunc_width-1:dout_width-1];
            // all top bits equal means the value fits
            if (&top || ~|top) begin
                return t[dout_width-1:0];
            end else if (t[trunc_width-1]) begin
                return {1'b1, {(dout_width-1){1'b0}}};
            end else begin
                return {1'b0, {(dout_width-1){1'b1}}};
            end
        endfunction

        assign cast_re = sat_rail(trunc_re);
        assign cast_im = sat_rail(trunc_im);
    end else begin : g_ext
        // integer part always fits, sign extension is enough
        assign cast_re = dout_width'(trunc_re);
        assign cast_im = dout_width'(trunc_im);
    end

    always_ff @(posedge clk) begin
        dout.re <= cast_re;
        dout.im <= cast_im;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= din_valid;
        end
    end

endmodule

`default_nettype wire

/* rtl/msdft.sv */
`default_nettype none

module msdft (
    input wire clk,
    input wire rst,
    input wire msdft_pkg::cplx_in_t din,
    input wire din_valid,
    input wire msdft_pkg::win_idx_t window_len_m1,
    output msdft_pkg::win_idx_t twidd_addr,
    output wire twidd_rd,
    input wire msdft_pkg::cplx_twidd_t twidd,
    output wire msdft_pkg::cplx_out_t dout,
    output wire dout_valid
);

    import fixed_pkg::*;
    import msdft_pkg::*;

    win_idx_t win_len_r;
    cplx_comb_t comb;
    logic comb_valid;
    cplx_comb_t comb_r;
    logic comb_r_valid;
    cplx_mod_t prod;
    logic prod_valid;
    cplx_integ_t integ;
    logic integ_valid;

    always_ff @(posedge clk) begin
        win_len_r <= window_len_m1;
    end

    sample_comb u_comb (
        .clk(clk),
        .rst(rst),
        .din(din),
        .din_valid(din_valid),
        .window_len_m1(win_len_r),
        .dout(comb),
        .dout_valid(comb_valid)
    );

    // rom read starts with the comb output and returns one cycle later
    assign twidd_rd = comb_valid;

    always_ff @(posedge clk) begin
        comb_r <= comb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            twidd_addr <= '0;
            comb_r_valid <= 1'b0;
        end else begin
            comb_r_valid <= comb_valid;
            if (comb_valid) begin
                if (twidd_addr == win_len_r) begin
                    twidd_addr <= '0;
                end else begin
                    twidd_addr <= twidd_addr + 1'b1;
                end
            end
        end
    end

    complex_mult u_mult (
        .clk(clk),
        .rst(rst),
        .a(comb_r),
        .b(twidd),
        .in_valid(comb_r_valid),
        .prod(prod),
        .out_valid(prod_valid)
    );

    // wrapping accumulator, the comb keeps it bounded
    always_ff @(posedge clk) begin
        if (rst) begin
            integ <= '0;
            integ_valid <= 1'b0;
        end else begin
            integ_valid <= prod_valid;
            if (prod_valid) begin
                integ.re <= integ.re + integ_width'(prod.re);
                integ.im <= integ.im + integ_width'(prod.im);
            end
        end
    end

    signed_cast u_cast (
        .clk(clk),
        .rst(rst),
        .din(integ),
        .din_valid(integ_valid),
        .dout(dout),
        .dout_valid(dout_valid)
    );

endmodule

`default_nettype wire

/* rtl/msdft_top.sv */
`default_nettype none

module msdft_top (
    input wire clk,
    input wire rst,
    input wire msdft_pkg::cplx_in_t din,
    input wire din_valid,
    input wire msdft_pkg::win_idx_t window_len_m1,
    output wire msdft_pkg::cplx_out_t dout,
    output wire dout_valid
);

    import msdft_pkg::*;

    win_idx_t twidd_addr;
    wire twidd_rd;
    cplx_twidd_t twidd;

    msdft u_core (
        .clk(clk),
        .rst(rst),
        .din(din),
        .din_valid(din_valid),
        .window_len_m1(window_len_m1),
        .twidd_addr(twidd_addr),
        .twidd_rd(twidd_rd),
        .twidd(twidd),
        .dout(dout),
        .dout_valid(dout_valid)
    );

    twiddle_rom u_rom (
        .clk(clk),
        .addr(twidd_addr),
        .rd(twidd_rd),
        .twidd(twidd)
    );

endmodule

`default_nettype wire

/* sim/clock_gen.sv */
`default_nettype none

module clock_gen (
    output logic clk
);

    localparam int period = 8;

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

/* sim/msdft_tb.sv */
`default_nettype none

module msdft_tb;

    import fixed_pkg::*;
    import msdft_pkg::*;

    localparam int clk_period = 8;
    localparam int reset_cycles = 10;
    localparam int latency = 6;
    localparam int n_impulse = 2 * dft_len;
    localparam int n_tone = dft_len;
    localparam int n_random = 600;
    localparam int n_full = 2 * dft_len;
    localparam int n_before_cut = 40;
    localparam int n_short = 4 * 32;
    localparam int total_samples = n_impulse + n_tone + n_random + n_full
                                   + n_before_cut + n_short;
    localparam int watchdog_cycles = total_samples * 20 + 500;
    localparam real two_pi = 2.0 * 3.14159265358979;

    logic clk;
    logic rst;
    cplx_in_t din;
    logic din_valid;
    win_idx_t window_len_m1;
    cplx_out_t dout;
    logic dout_valid;

    // reference model state
    cplx_in_t hist [$];
    cplx_out_t exp_q [$];
    cplx_out_t exp_cur;
    longint acc_re;
    longint acc_im;
    int win_len;
    logic [latency-1:0] valid_hist;
    integer seed;
    string test_name;

    clock_gen u_clk (
        .clk(clk)
    );

    msdft_top uut (
        .clk(clk),
        .rst(rst),
        .din(din),
        .din_valid(din_valid),
        .window_len_m1(window_len_m1),
        .dout(dout),
        .dout_valid(dout_valid)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string cplx_str(input cplx_out_t v);
        return $sformatf("(%0d, %0d)", v.re, v.im);
    endfunction

    // integrator wraps at integ_width bits
    function automatic longint wrap_integ(input longint v);
        logic signed [integ_width-1:0] w;
        w = v[integ_width-1:0];
        return longint'(w);
    endfunction

    // floor of the extra fraction bits, then clamp to the output range
    function automatic logic signed [dout_width-1:0] to_dout(input longint v);
        longint t;
        longint hi;
        t = v >>> (mod_point - dout_point);
        hi = (longint'(1) <<< (dout_width - 1)) - 1;
        if (t > hi) begin
            t = hi;
        end else if (t < -hi - 1) begin
            t = -hi - 1;
        end
        return dout_width'(t);
    endfunction

    task automatic model_sample(input cplx_in_t s);
        int k;
        int c_re;
        int c_im;
        logic [2*twidd_width-1:0] tw;
        longint w_re;
        longint w_im;
        cplx_out_t e;
        k = hist.size();
        c_re = int'(s.re);
        c_im = int'(s.im);
        // the sample leaving a filled window is subtracted
        if (k >= win_len) begin
            c_re = c_re - int'(hist[k - win_len].re);
            c_im = c_im - int'(hist[k - win_len].im);
        end
        tw = twiddle_value(k % win_len);
        w_re = longint'($signed(tw[2*twidd_width-1:twidd_width]));
        w_im = longint'($signed(tw[twidd_width-1:0]));
        acc_re = wrap_integ(acc_re + c_re * w_re - c_im * w_im);
        acc_im = wrap_integ(acc_im + c_re * w_im + c_im * w_re);
        e.re = to_dout(acc_re);
        e.im = to_dout(acc_im);
        hist.push_back(s);
        exp_q.push_back(e);
    endtask

    task automatic apply_reset(input int len_m1);
        @(negedge clk);
        rst = 1'b1;
        din_valid = 1'b0;
        window_len_m1 = win_idx_t'(len_m1);
        // samples still in the pipeline are flushed by the reset
        exp_q.delete();
        hist.delete();
        acc_re = 0;
        acc_im = 0;
        win_len = len_m1 + 1;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic send(input cplx_in_t s);
        @(negedge clk);
        din = s;
        din_valid = 1'b1;
        model_sample(s);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        din_valid = 1'b0;
    endtask

    task automatic drain();
        idle_cycle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // last compare happens on the following rising edge
        repeat (2) @(negedge clk);
    endtask

    function automatic cplx_in_t random_sample();
        cplx_in_t s;
        s.re = din_width'($random(seed));
        s.im = din_width'($random(seed));
        return s;
    endfunction

    // complex tone rotating at the tracked bin
    function automatic cplx_in_t tone_sample(input int n, input real amp);
        real theta;
        cplx_in_t s;
        theta = two_pi * real'(twiddle_bin * n) / real'(dft_len);
        s.re = din_width'(int'(amp * $cos(theta)));
        s.im = din_width'(int'(amp * $sin(theta)));
        return s;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[latency-2:0], din_valid};
        end
    end

    // dout is stable at the falling edge, so the next expected value is taken there
    always @(negedge clk) begin
        if (!rst && dout_valid) begin
            if (exp_q.size() == 0) begin
                fail_run($sformatf("output in test %s with no sample pending", test_name));
            end else begin
                exp_cur = exp_q.pop_front();
            end
        end
    end

    check_dout: assert property (@(posedge clk) (!rst && dout_valid) |-> (dout == exp_cur))
        else fail_run($sformatf("ERR %s expected %s actual %s", test_name,
                                cplx_str($sampled(exp_cur)), cplx_str($sampled(dout))));

    check_latency: assert property (@(posedge clk) !rst |-> (dout_valid == valid_hist[latency-1]))
        else fail_run($sformatf("ERR %s dout_valid expected %0b actual %0b", test_name,
                                $sampled(valid_hist[latency-1]), $sampled(dout_valid)));

    initial begin
        #(watchdog_cycles * clk_period);
        fail_run("timeout, the tests did not finish within the watchdog time");
    end

    initial begin
        cplx_in_t s;
        int n;
        seed = 16845;
        rst = 1'b1;
        din = '0;
        din_valid = 1'b0;
        window_len_m1 = win_idx_t'(dft_len - 1);
        exp_cur = '0;
        acc_re = 0;
        acc_im = 0;
        win_len = dft_len;

        test_name = "impulse";
        apply_reset(dft_len - 1);
        s.re = 8'sd127;
        s.im = '0;
        send(s);
        s.re = '0;
        repeat (n_impulse - 1) send(s);
        drain();

        test_name = "tone";
        apply_reset(dft_len - 1);
        for (n = 0; n < n_tone; n++) begin
            send(tone_sample(n, 100.0));
        end
        drain();

        test_name = "random_gaps";
        apply_reset(dft_len - 1);
        for (n = 0; n < n_random; n++) begin
            if (($random(seed) & 3) == 0) begin
                idle_cycle();
            end
            send(random_sample());
        end
        drain();

        // full scale tone, then its negative, for the widest swing both ways
        test_name = "full_scale";
        apply_reset(dft_len - 1);
        for (n = 0; n < n_full; n++) begin
            send(tone_sample(n, (n < dft_len) ? 127.0 : -127.0));
        end
        drain();

        test_name = "reset_short_window";
        apply_reset(dft_len - 1);
        repeat (n_before_cut) send(random_sample());
        apply_reset(31);
        repeat (n_short) send(random_sample());
        drain();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/fixed_pkg.sv
rtl/msdft_pkg.sv
rtl/sample_comb.sv
rtl/twiddle_rom.sv
rtl/complex_mult.sv
rtl/signed_cast.sv
rtl/msdft.sv
rtl/msdft_top.sv
sim/clock_gen.sv
sim/msdft_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the msdft testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module msdft_tb -o msdft_sim

# the simulator exits non-zero on failure, the log decides the result
./obj_dir/msdft_sim 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
